//--- flist.f
+incdir+common
common/mem_pkg.sv
common/noc_pkg.sv
src/bridge_cfg.sv
bridge/dram_hash.sv
bridge/return_tracker.sv
bridge/bridge_core.sv
src/noc_endpoint.sv
src/dram_bridge_top.sv
verif/tb_dram_bridge.sv

//--- Bender.yml
package:
  name: dram_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - common/noc_pkg.sv
      - src/bridge_cfg.sv
      - bridge/dram_hash.sv
      - bridge/return_tracker.sv
      - bridge/bridge_core.sv
      - src/noc_endpoint.sv
      - src/dram_bridge_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_dram_bridge.sv

//--- verif/tb_dram_bridge.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module tb_dram_bridge;

  import mem_pkg::*;
  import noc_pkg::*;

  localparam int clk_period = 20;
  localparam int n_txn      = 88;
  localparam int loc_w      = `NOC_X_W + `NOC_Y_W + `NOC_ADDR_W;
  localparam int req_w      = loc_w + `DATA_W + `NOC_X_W + `NOC_Y_W + `REG_ID_W;
  localparam int rev_w      = `PADDR_W + `TAG_W + `DATA_W;

  logic                   clk_i;
  logic                   rst_n_i;
  mem_msg_e               mem_fwd_type_i;
  logic [`PADDR_W-1:0]    mem_fwd_addr_i;
  logic [`TAG_W-1:0]      mem_fwd_tag_i;
  logic [`DATA_W-1:0]     mem_fwd_data_i;
  logic                   mem_fwd_v_i;
  logic                   mem_fwd_ready_and_o;
  mem_msg_e               mem_rev_type_o;
  logic [`PADDR_W-1:0]    mem_rev_addr_o;
  logic [`TAG_W-1:0]      mem_rev_tag_o;
  logic [`DATA_W-1:0]     mem_rev_data_o;
  logic                   mem_rev_v_o;
  logic                   mem_rev_ready_and_i;
  logic                   noc_req_v_o;
  noc_op_e                noc_req_op_o;
  logic [`NOC_X_W-1:0]    noc_req_x_o;
  logic [`NOC_Y_W-1:0]    noc_req_y_o;
  logic [`NOC_ADDR_W-1:0] noc_req_addr_o;
  logic [`DATA_W-1:0]     noc_req_data_o;
  logic [`NOC_X_W-1:0]    noc_req_src_x_o;
  logic [`NOC_Y_W-1:0]    noc_req_src_y_o;
  logic [`REG_ID_W-1:0]   noc_req_reg_id_o;
  logic                   noc_ret_v_i;
  logic [`REG_ID_W-1:0]   noc_ret_reg_id_i;
  logic [`DATA_W-1:0]     noc_ret_data_i;
  logic                   cfg_we_i;
  logic [1:0]             cfg_addr_i;
  logic [`DATA_W-1:0]     cfg_data_i;

  // pre-built stimulus with one entry per forward message
  mem_msg_e            msg_type [n_txn];
  logic [`PADDR_W-1:0] msg_addr [n_txn];
  logic [`TAG_W-1:0]   msg_tag  [n_txn];
  logic [`DATA_W-1:0]  msg_data [n_txn];
  logic                msg_gap  [n_txn];

  // software view of the configuration registers
  logic [`PADDR_W-2:0] sh_offset;
  logic [`POD_X_W-1:0] sh_pod_x;
  logic [`POD_Y_W-1:0] sh_pod_y;
  logic [`NOC_X_W-1:0] sh_src_x;
  logic [`NOC_Y_W-1:0] sh_src_y;

  // expected traffic in acceptance order
  noc_op_e            exp_op_q   [$];
  logic [req_w-1:0]   exp_req_q  [$];
  mem_msg_e           exp_type_q [$];
  logic [rev_w-1:0]   exp_rev_q  [$];
  logic [`DATA_W-1:0] ref_mem    [logic [loc_w-1:0]];

  // network model state
  logic [`DATA_W-1:0]   model_mem   [logic [loc_w-1:0]];
  noc_op_e              pend_op_q   [$];
  logic [loc_w-1:0]     pend_loc_q  [$];
  logic [`DATA_W-1:0]   pend_data_q [$];
  logic [`REG_ID_W-1:0] pend_id_q   [$];
  int                   pend_due_q  [$];

  logic [31:0] lfsr_state;
  int          cycle;
  int          outstanding;
  int          stall_level;
  int          n_rev;
  int          n_acc;

  dram_bridge_top uut (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  // --------------------
  // helpers
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // destination {x, y, word address} for an address under a given configuration
  function automatic logic [loc_w-1:0] hash_ref(input logic [`PADDR_W-1:0] addr,
                                                input logic [`PADDR_W-2:0] offset,
                                                input logic [`POD_X_W-1:0] pod_x,
                                                input logic [`POD_Y_W-1:0] pod_y);
    logic [`PADDR_W-2:0]   eva;
    logic [2:0]            bank;
    logic [`NOC_X_W-1:0]   x;
    logic [`NOC_Y_W-1:0]   y;
    logic [`NOC_ADDR_W-1:0] epa;
    eva  = addr[`PADDR_W-2:0] + offset;
    bank = eva[7:5];
    x    = pod_x * `TILES_X + bank[1:0];
    y    = pod_y * (`TILES_Y + 2) + (bank[2] ? `TILES_Y + 1 : 0);
    epa  = {eva[30:8], eva[4:2]};
    return {x, y, epa};
  endfunction

  task automatic check_req(input noc_op_e got_op, input noc_op_e exp_op,
                           input logic [req_w-1:0] got, input logic [req_w-1:0] exp);
    if (got_op !== exp_op || got !== exp)
      abort_run($sformatf("FAIL at %0t ns: request op %0d fields %h, expected op %0d fields %h",
                          $time, got_op, got, exp_op, exp));
  endtask

  task automatic check_rev(input mem_msg_e got_type, input mem_msg_e exp_type,
                           input logic [rev_w-1:0] got, input logic [rev_w-1:0] exp);
    if (got_type !== exp_type || got !== exp)
      abort_run($sformatf("FAIL at %0t ns: reverse type %0d fields %h, expected %0d fields %h",
                          $time, got_type, got, exp_type, exp));
  endtask

  // --------------------
  // stimulus
  task automatic build_stimulus();
    logic [31:0] r;
    for (int i = 0; i < n_txn; i++)
    begin
      take_bits(32, r);
      msg_data[i] = r;
      take_bits(`TAG_W, r);
      msg_tag[i] = r[`TAG_W-1:0];
      take_bits(2, r);
      msg_gap[i] = (r[1:0] == 2'b00);
      take_bits(1, r);
      msg_type[i] = r[0] ? e_mem_wr : e_mem_rd;
    end
    // writes followed by reads of the same words in reverse order
    for (int i = 0; i < 16; i++)
    begin
      msg_type[i]      = e_mem_wr;
      msg_addr[i]      = 32'h1000 + i * 36;
      msg_type[16 + i] = e_mem_rd;
      msg_addr[16 + i] = 32'h1000 + (15 - i) * 36;
    end
    // words never written
    for (int i = 32; i < 40; i++)
    begin
      msg_type[i] = e_mem_rd;
      msg_addr[i] = 32'h8000 + i * 36;
    end
    // mixed burst after reconfiguration followed by reads of half of it
    for (int i = 0; i < 32; i++)
      msg_addr[40 + i] = 32'h1000 + i * 28;
    for (int i = 0; i < 16; i++)
    begin
      msg_type[72 + i] = e_mem_rd;
      msg_addr[72 + i] = msg_addr[40 + 2 * i];
    end
  endtask

  task automatic write_cfg(input logic [1:0] addr, input logic [`DATA_W-1:0] data);
    @(negedge clk_i);
    cfg_we_i   = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
    case (addr)
      2'd0: sh_offset = data[`PADDR_W-2:0];
      2'd1:
      begin
        sh_pod_y = data[2:0];
        sh_pod_x = data[5:3];
      end
      2'd2:
      begin
        sh_src_y = data[6:0];
        sh_src_x = data[13:7];
      end
      default: ;
    endcase
  endtask

  task automatic send_msg(input int i);
    logic [loc_w-1:0]     loc;
    logic [`DATA_W-1:0]   old_data;
    logic [`DATA_W-1:0]   rev_data;
    logic [`REG_ID_W-1:0] exp_id;
    @(negedge clk_i);
    mem_fwd_v_i    = 1'b1;
    mem_fwd_type_i = msg_type[i];
    mem_fwd_addr_i = msg_addr[i];
    mem_fwd_tag_i  = msg_tag[i];
    mem_fwd_data_i = msg_data[i];
    @(posedge clk_i);
    while (!mem_fwd_ready_and_o)
      @(posedge clk_i);
    // accepted at this edge
    loc      = hash_ref(msg_addr[i], sh_offset, sh_pod_x, sh_pod_y);
    old_data = ref_mem.exists(loc) ? ref_mem[loc] : '0;
    rev_data = (msg_type[i] == e_mem_wr) ? msg_data[i] : old_data;
    if (msg_type[i] == e_mem_wr)
      ref_mem[loc] = msg_data[i];
    // ids are handed out round-robin in acceptance order
    exp_id = n_acc % `OUTSTANDING;
    n_acc  = n_acc + 1;
    exp_op_q.push_back((msg_type[i] == e_mem_wr) ? e_remote_sw : e_remote_load);
    exp_req_q.push_back({loc, msg_data[i], sh_src_x, sh_src_y, exp_id});
    exp_type_q.push_back(msg_type[i]);
    exp_rev_q.push_back({msg_addr[i], msg_tag[i], rev_data});
  endtask

  task automatic run_burst(input int first, input int count);
    for (int i = first; i < first + count; i++)
    begin
      if (msg_gap[i])
      begin
        @(negedge clk_i);
        mem_fwd_v_i = 1'b0;
      end
      send_msg(i);
    end
    @(negedge clk_i);
    mem_fwd_v_i = 1'b0;
    while (exp_rev_q.size() != 0)
      @(posedge clk_i);
  endtask

  // --------------------
  // network model
  always @(posedge clk_i)
  begin : model_collect
    logic [31:0] r;
    cycle = cycle + 1;
    if (noc_req_v_o)
    begin
      take_bits(3, r);
      pend_op_q.push_back(noc_req_op_o);
      pend_loc_q.push_back({noc_req_x_o, noc_req_y_o, noc_req_addr_o});
      pend_data_q.push_back(noc_req_data_o);
      pend_id_q.push_back(noc_req_reg_id_o);
      pend_due_q.push_back(cycle + int'(r));
    end
  end

  // at most one return per cycle picked at random from the pending list
  always @(negedge clk_i)
  begin : model_serve
    logic [31:0] r;
    int          idx;
    take_bits(3, r);
    mem_rev_ready_and_i = (int'(r) >= stall_level);
    noc_ret_v_i         = 1'b0;
    if (pend_id_q.size() != 0)
    begin
      take_bits(4, r);
      idx = int'(r) % pend_id_q.size();
      if (pend_due_q[idx] <= cycle)
      begin
        noc_ret_v_i      = 1'b1;
        noc_ret_reg_id_i = pend_id_q[idx];
        if (pend_op_q[idx] == e_remote_sw)
        begin
          model_mem[pend_loc_q[idx]] = pend_data_q[idx];
          noc_ret_data_i             = pend_data_q[idx];
        end
        else
          noc_ret_data_i = model_mem.exists(pend_loc_q[idx]) ? model_mem[pend_loc_q[idx]] : '0;
        pend_op_q.delete(idx);
        pend_loc_q.delete(idx);
        pend_data_q.delete(idx);
        pend_id_q.delete(idx);
        pend_due_q.delete(idx);
      end
    end
  end

  // --------------------
  // compare
  always @(posedge clk_i)
  begin : compare
    if (rst_n_i)
    begin
      if (noc_req_v_o && exp_op_q.size() == 0)
        abort_run("network request seen without an accepted forward message");
      else if (noc_req_v_o)
        check_req(noc_req_op_o, exp_op_q.pop_front(),
                  {noc_req_x_o, noc_req_y_o, noc_req_addr_o, noc_req_data_o,
                   noc_req_src_x_o, noc_req_src_y_o, noc_req_reg_id_o},
                  exp_req_q.pop_front());
      if (mem_rev_v_o && mem_rev_ready_and_i && exp_type_q.size() == 0)
        abort_run("reverse message seen without an accepted forward message");
      else if (mem_rev_v_o && mem_rev_ready_and_i)
      begin
        n_rev = n_rev + 1;
        check_rev(mem_rev_type_o, exp_type_q.pop_front(),
                  {mem_rev_addr_o, mem_rev_tag_o, mem_rev_data_o}, exp_rev_q.pop_front());
      end
      outstanding = outstanding + int'(noc_req_v_o) - int'(noc_ret_v_i);
      if (outstanding > `NOC_CREDITS)
        abort_run("more network requests in flight than the credit limit allows");
    end
  end

  initial
  begin : watchdog
    #(n_txn * 200 * clk_period);
    abort_run($sformatf("timeout with %0d reverse messages still missing", n_txn - n_rev));
  end

  initial
  begin
    lfsr_state          = 32'h7715e93e;
    clk_i               = 1'b0;
    rst_n_i             = 1'b0;
    mem_fwd_type_i      = e_mem_rd;
    mem_fwd_addr_i      = '0;
    mem_fwd_tag_i       = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    noc_ret_v_i         = 1'b0;
    noc_ret_reg_id_i    = '0;
    noc_ret_data_i      = '0;
    cfg_we_i            = 1'b0;
    cfg_addr_i          = '0;
    cfg_data_i          = '0;
    {sh_offset, sh_pod_x, sh_pod_y, sh_src_x, sh_src_y} = '0;
    cycle       = 0;
    outstanding = 0;
    n_rev       = 0;
    n_acc       = 0;
    stall_level = 2;
    build_stimulus();
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    if (!mem_fwd_ready_and_o || mem_rev_v_o || noc_req_v_o)
      abort_run("bridge outputs are not idle after reset");
    write_cfg(2'd2, {18'd0, 7'd5, 7'd3});
    write_cfg(2'd0, 32'h0000_4000);
    write_cfg(2'd1, {26'd0, 3'd1, 3'd2});
    run_burst(0, 16);
    run_burst(16, 24);
    // heavy reverse back-pressure fills the tracker
    stall_level = 6;
    write_cfg(2'd0, 32'h0123_4560);
    write_cfg(2'd1, {26'd0, 3'd3, 3'd5});
    run_burst(40, 32);
    stall_level = 1;
    run_burst(72, 16);
    if (n_rev != n_txn || exp_req_q.size() != 0 || pend_id_q.size() != 0 || outstanding != 0)
      abort_run("traffic lost or left over at the end of the run");
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- src/dram_bridge_top.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module dram_bridge_top
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mem_pkg::mem_msg_e       mem_fwd_type_i,
    input  logic [`PADDR_W-1:0]     mem_fwd_addr_i,
    input  logic [`TAG_W-1:0]       mem_fwd_tag_i,
    input  logic [`DATA_W-1:0]      mem_fwd_data_i,
    input  logic                    mem_fwd_v_i,
    output logic                    mem_fwd_ready_and_o,
    output mem_pkg::mem_msg_e       mem_rev_type_o,
    output logic [`PADDR_W-1:0]     mem_rev_addr_o,
    output logic [`TAG_W-1:0]       mem_rev_tag_o,
    output logic [`DATA_W-1:0]      mem_rev_data_o,
    output logic                    mem_rev_v_o,
    input  logic                    mem_rev_ready_and_i,
    output logic                    noc_req_v_o,
    output noc_pkg::noc_op_e        noc_req_op_o,
    output logic [`NOC_X_W-1:0]     noc_req_x_o,
    output logic [`NOC_Y_W-1:0]     noc_req_y_o,
    output logic [`NOC_ADDR_W-1:0]  noc_req_addr_o,
    output logic [`DATA_W-1:0]      noc_req_data_o,
    output logic [`NOC_X_W-1:0]     noc_req_src_x_o,
    output logic [`NOC_Y_W-1:0]     noc_req_src_y_o,
    output logic [`REG_ID_W-1:0]    noc_req_reg_id_o,
    input  logic                    noc_ret_v_i,
    input  logic [`REG_ID_W-1:0]    noc_ret_reg_id_i,
    input  logic [`DATA_W-1:0]      noc_ret_data_i,
    input  logic                    cfg_we_i,
    input  logic [1:0]              cfg_addr_i,
    input  logic [`DATA_W-1:0]      cfg_data_i
  );

  import noc_pkg::*;

  // configuration fields
  logic [`PADDR_W-2:0] cfg_offset;
  logic [`POD_X_W-1:0] cfg_pod_x;
  logic [`POD_Y_W-1:0] cfg_pod_y;
  logic [`NOC_X_W-1:0] cfg_src_x;
  logic [`NOC_Y_W-1:0] cfg_src_y;

  // core to endpoint queue
  logic                   q_ready;
  logic                   q_v;
  noc_op_e                q_op;
  logic [`NOC_X_W-1:0]    q_x;
  logic [`NOC_Y_W-1:0]    q_y;
  logic [`NOC_ADDR_W-1:0] q_addr;
  logic [`DATA_W-1:0]     q_data;
  logic [`NOC_X_W-1:0]    q_src_x;
  logic [`NOC_Y_W-1:0]    q_src_y;
  logic [`REG_ID_W-1:0]   q_reg_id;

  // endpoint to core returns
  logic                 ret_v;
  logic [`REG_ID_W-1:0] ret_reg_id;
  logic [`DATA_W-1:0]   ret_data;

  bridge_cfg cfg
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_data_i   (cfg_data_i),
      .cfg_offset_o (cfg_offset),
      .cfg_pod_x_o  (cfg_pod_x),
      .cfg_pod_y_o  (cfg_pod_y),
      .cfg_src_x_o  (cfg_src_x),
      .cfg_src_y_o  (cfg_src_y)
    );

  bridge_core core
    (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .mem_fwd_type_i      (mem_fwd_type_i),
      .mem_fwd_addr_i      (mem_fwd_addr_i),
      .mem_fwd_tag_i       (mem_fwd_tag_i),
      .mem_fwd_data_i      (mem_fwd_data_i),
      .mem_fwd_v_i         (mem_fwd_v_i),
      .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
      .mem_rev_type_o      (mem_rev_type_o),
      .mem_rev_addr_o      (mem_rev_addr_o),
      .mem_rev_tag_o       (mem_rev_tag_o),
      .mem_rev_data_o      (mem_rev_data_o),
      .mem_rev_v_o         (mem_rev_v_o),
      .mem_rev_ready_and_i (mem_rev_ready_and_i),
      .cfg_offset_i        (cfg_offset),
      .cfg_pod_x_i         (cfg_pod_x),
      .cfg_pod_y_i         (cfg_pod_y),
      .cfg_src_x_i         (cfg_src_x),
      .cfg_src_y_i         (cfg_src_y),
      .q_ready_i           (q_ready),
      .ret_v_i             (ret_v),
      .ret_reg_id_i        (ret_reg_id),
      .ret_data_i          (ret_data),
      .q_v_o               (q_v),
      .q_op_o              (q_op),
      .q_x_o               (q_x),
      .q_y_o               (q_y),
      .q_addr_o            (q_addr),
      .q_data_o            (q_data),
      .q_src_x_o           (q_src_x),
      .q_src_y_o           (q_src_y),
      .q_reg_id_o          (q_reg_id)
    );

  noc_endpoint endpoint
    (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .q_v_i            (q_v),
      .q_op_i           (q_op),
      .q_x_i            (q_x),
      .q_y_i            (q_y),
      .q_addr_i         (q_addr),
      .q_data_i         (q_data),
      .q_src_x_i        (q_src_x),
      .q_src_y_i        (q_src_y),
      .q_reg_id_i       (q_reg_id),
      .noc_ret_v_i      (noc_ret_v_i),
      .noc_ret_reg_id_i (noc_ret_reg_id_i),
      .noc_ret_data_i   (noc_ret_data_i),
      .q_ready_o        (q_ready),
      .noc_req_v_o      (noc_req_v_o),
      .noc_req_op_o     (noc_req_op_o),
      .noc_req_x_o      (noc_req_x_o),
      .noc_req_y_o      (noc_req_y_o),
      .noc_req_addr_o   (noc_req_addr_o),
      .noc_req_data_o   (noc_req_data_o),
      .noc_req_src_x_o  (noc_req_src_x_o),
      .noc_req_src_y_o  (noc_req_src_y_o),
      .noc_req_reg_id_o (noc_req_reg_id_o),
      .ret_v_o          (ret_v),
      .ret_reg_id_o     (ret_reg_id),
      .ret_data_o       (ret_data)
    );

endmodule

//--- src/noc_endpoint.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module noc_endpoint
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    q_v_i,
    input  noc_pkg::noc_op_e        q_op_i,
    input  logic [`NOC_X_W-1:0]     q_x_i,
    input  logic [`NOC_Y_W-1:0]     q_y_i,
    input  logic [`NOC_ADDR_W-1:0]  q_addr_i,
    input  logic [`DATA_W-1:0]      q_data_i,
    input  logic [`NOC_X_W-1:0]     q_src_x_i,
    input  logic [`NOC_Y_W-1:0]     q_src_y_i,
    input  logic [`REG_ID_W-1:0]    q_reg_id_i,
    input  logic                    noc_ret_v_i,
    input  logic [`REG_ID_W-1:0]    noc_ret_reg_id_i,
    input  logic [`DATA_W-1:0]      noc_ret_data_i,
    output logic                    q_ready_o,
    output logic                    noc_req_v_o,
    output noc_pkg::noc_op_e        noc_req_op_o,
    output logic [`NOC_X_W-1:0]     noc_req_x_o,
    output logic [`NOC_Y_W-1:0]     noc_req_y_o,
    output logic [`NOC_ADDR_W-1:0]  noc_req_addr_o,
    output logic [`DATA_W-1:0]      noc_req_data_o,
    output logic [`NOC_X_W-1:0]     noc_req_src_x_o,
    output logic [`NOC_Y_W-1:0]     noc_req_src_y_o,
    output logic [`REG_ID_W-1:0]    noc_req_reg_id_o,
    output logic                    ret_v_o,
    output logic [`REG_ID_W-1:0]    ret_reg_id_o,
    output logic [`DATA_W-1:0]      ret_data_o
  );

  import noc_pkg::*;

  localparam int els      = `NOC_FIFO_ELS;
  localparam int ptr_w    = (els > 1) ? $clog2(els) : 1;
  localparam int cnt_w    = $clog2(els + 1);
  localparam int credit_w = $clog2(`NOC_CREDITS + 1);
  localparam int op_w     = $bits(noc_op_e);
  localparam int pkt_w    = op_w + 2 * (`NOC_X_W + `NOC_Y_W) + `NOC_ADDR_W + `DATA_W
                            + `REG_ID_W;

  logic [pkt_w-1:0]    pkt_mem [els];
  logic [pkt_w-1:0]    wr_pkt;
  logic [pkt_w-1:0]    rd_pkt;
  logic [op_w-1:0]     rd_op;
  logic [ptr_w-1:0]    wr_ptr_r;
  logic [ptr_w-1:0]    rd_ptr_r;
  logic [cnt_w-1:0]    count_r;
  logic [credit_w-1:0] credits_used_r;
  logic                enq;
  logic                send;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(els - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------
  // request queue
  assign q_ready_o = (count_r != cnt_w'(els));
  assign enq       = q_v_i & q_ready_o;

  // head leaves only while a credit is left
  assign send = (count_r != '0) && (credits_used_r < credit_w'(`NOC_CREDITS));

  assign wr_pkt = {q_op_i, q_x_i, q_y_i, q_addr_i, q_data_i, q_src_x_i, q_src_y_i, q_reg_id_i};
  assign rd_pkt = pkt_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq)
      pkt_mem[wr_ptr_r] <= wr_pkt;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r       <= '0;
      rd_ptr_r       <= '0;
      count_r        <= '0;
      credits_used_r <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (send)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      count_r <= count_r + cnt_w'(enq) - cnt_w'(send);
      // a send and a return in one cycle cancel out
      credits_used_r <= credits_used_r + credit_w'(send) - credit_w'(noc_ret_v_i);
    end
  end

  assign noc_req_v_o = send;
  assign {rd_op, noc_req_x_o, noc_req_y_o, noc_req_addr_o, noc_req_data_o,
          noc_req_src_x_o, noc_req_src_y_o, noc_req_reg_id_o} = rd_pkt;
  assign noc_req_op_o = noc_op_e'(rd_op);

  // --------------------
  // returns go straight to the tracker
  assign ret_v_o      = noc_ret_v_i;
  assign ret_reg_id_o = noc_ret_reg_id_i;
  assign ret_data_o   = noc_ret_data_i;

endmodule

//--- bridge/bridge_core.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module bridge_core
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mem_pkg::mem_msg_e       mem_fwd_type_i,
    input  logic [`PADDR_W-1:0]     mem_fwd_addr_i,
    input  logic [`TAG_W-1:0]       mem_fwd_tag_i,
    input  logic [`DATA_W-1:0]      mem_fwd_data_i,
    input  logic                    mem_fwd_v_i,
    output logic                    mem_fwd_ready_and_o,
    output mem_pkg::mem_msg_e       mem_rev_type_o,
    output logic [`PADDR_W-1:0]     mem_rev_addr_o,
    output logic [`TAG_W-1:0]       mem_rev_tag_o,
    output logic [`DATA_W-1:0]      mem_rev_data_o,
    output logic                    mem_rev_v_o,
    input  logic                    mem_rev_ready_and_i,
    input  logic [`PADDR_W-2:0]     cfg_offset_i,
    input  logic [`POD_X_W-1:0]     cfg_pod_x_i,
    input  logic [`POD_Y_W-1:0]     cfg_pod_y_i,
    input  logic [`NOC_X_W-1:0]     cfg_src_x_i,
    input  logic [`NOC_Y_W-1:0]     cfg_src_y_i,
    input  logic                    q_ready_i,
    input  logic                    ret_v_i,
    input  logic [`REG_ID_W-1:0]    ret_reg_id_i,
    input  logic [`DATA_W-1:0]      ret_data_i,
    output logic                    q_v_o,
    output noc_pkg::noc_op_e        q_op_o,
    output logic [`NOC_X_W-1:0]     q_x_o,
    output logic [`NOC_Y_W-1:0]     q_y_o,
    output logic [`NOC_ADDR_W-1:0]  q_addr_o,
    output logic [`DATA_W-1:0]      q_data_o,
    output logic [`NOC_X_W-1:0]     q_src_x_o,
    output logic [`NOC_Y_W-1:0]     q_src_y_o,
    output logic [`REG_ID_W-1:0]    q_reg_id_o
  );

  import mem_pkg::*;
  import noc_pkg::*;

  localparam int id_w  = $clog2(`OUTSTANDING);
  localparam int rid_w = `REG_ID_W;

  dram_eva_u           eva;
  logic [`PADDR_W-2:0] dram_addr;
  logic                alloc_v;
  logic [id_w-1:0]     alloc_id;
  logic                rev_yumi;

  // --------------------
  // address translation
  assign dram_addr  = mem_fwd_addr_i[`PADDR_W-2:0] + cfg_offset_i;
  assign eva.offset = '{dram: 1'b1, addr: dram_addr};

  dram_hash hash
    (
      .eva_i   (eva),
      .pod_x_i (cfg_pod_x_i),
      .pod_y_i (cfg_pod_y_i),
      .x_o     (q_x_o),
      .y_o     (q_y_o),
      .epa_o   (q_addr_o)
    );

  // --------------------
  // outgoing request
  // ready needs a free id and room in the queue, never valid
  assign mem_fwd_ready_and_o = alloc_v & q_ready_i;
  assign q_v_o               = mem_fwd_v_i & mem_fwd_ready_and_o;

  assign q_op_o     = (mem_fwd_type_i == e_mem_wr) ? e_remote_sw : e_remote_load;
  assign q_data_o   = mem_fwd_data_i;
  assign q_src_x_o  = cfg_src_x_i;
  assign q_src_y_o  = cfg_src_y_i;
  assign q_reg_id_o = rid_w'(alloc_id);

  // reverse channel drains the tracker head
  assign rev_yumi = mem_rev_v_o & mem_rev_ready_and_i;

  return_tracker #(.els_p(`OUTSTANDING)) tracker
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .alloc_yumi_i (q_v_o),
      .hdr_type_i   (mem_fwd_type_i),
      .hdr_addr_i   (mem_fwd_addr_i),
      .hdr_tag_i    (mem_fwd_tag_i),
      .ret_v_i      (ret_v_i),
      .ret_id_i     (ret_reg_id_i[id_w-1:0]),
      .ret_data_i   (ret_data_i),
      .deq_yumi_i   (rev_yumi),
      .alloc_v_o    (alloc_v),
      .alloc_id_o   (alloc_id),
      .deq_v_o      (mem_rev_v_o),
      .deq_type_o   (mem_rev_type_o),
      .deq_addr_o   (mem_rev_addr_o),
      .deq_tag_o    (mem_rev_tag_o),
      .deq_data_o   (mem_rev_data_o)
    );

endmodule

//--- bridge/return_tracker.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module return_tracker
  #(
    parameter int els_p = `OUTSTANDING,
    localparam int id_w = $clog2(els_p)
  )
  (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 alloc_yumi_i,
    input  mem_pkg::mem_msg_e    hdr_type_i,
    input  logic [`PADDR_W-1:0]  hdr_addr_i,
    input  logic [`TAG_W-1:0]    hdr_tag_i,
    input  logic                 ret_v_i,
    input  logic [id_w-1:0]      ret_id_i,
    input  logic [`DATA_W-1:0]   ret_data_i,
    input  logic                 deq_yumi_i,
    output logic                 alloc_v_o,
    output logic [id_w-1:0]      alloc_id_o,
    output logic                 deq_v_o,
    output mem_pkg::mem_msg_e    deq_type_o,
    output logic [`PADDR_W-1:0]  deq_addr_o,
    output logic [`TAG_W-1:0]    deq_tag_o,
    output logic [`DATA_W-1:0]   deq_data_o
  );

  import mem_pkg::*;

  // busy marks an id in use, done marks a reply that has arrived
  logic [els_p-1:0] busy_r;
  logic [els_p-1:0] done_r;
  logic [id_w-1:0]  alloc_ptr_r;
  logic [id_w-1:0]  deq_ptr_r;

  mem_msg_e            type_mem [els_p];
  logic [`PADDR_W-1:0] addr_mem [els_p];
  logic [`TAG_W-1:0]   tag_mem  [els_p];
  logic [`DATA_W-1:0]  data_mem [els_p];

  function automatic logic [id_w-1:0] next_id(input logic [id_w-1:0] id);
    return (id == id_w'(els_p - 1)) ? '0 : id + 1'b1;
  endfunction

  // --------------------
  // control state
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r      <= '0;
      done_r      <= '0;
      alloc_ptr_r <= '0;
      deq_ptr_r   <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
      begin
        busy_r[alloc_ptr_r] <= 1'b1;
        alloc_ptr_r         <= next_id(alloc_ptr_r);
      end
      // ids are reserved, so a reply never hits a free entry
      if (ret_v_i)
        done_r[ret_id_i] <= 1'b1;
      if (deq_yumi_i)
      begin
        busy_r[deq_ptr_r] <= 1'b0;
        done_r[deq_ptr_r] <= 1'b0;
        deq_ptr_r         <= next_id(deq_ptr_r);
      end
    end
  end

  // --------------------
  // header and reply storage
  always_ff @(posedge clk_i)
  begin
    if (alloc_yumi_i)
    begin
      type_mem[alloc_ptr_r] <= hdr_type_i;
      addr_mem[alloc_ptr_r] <= hdr_addr_i;
      tag_mem[alloc_ptr_r]  <= hdr_tag_i;
    end
    if (ret_v_i)
      data_mem[ret_id_i] <= ret_data_i;
  end

  // the next id is free unless the tracker has wrapped onto the oldest entry
  assign alloc_v_o  = ~busy_r[alloc_ptr_r];
  assign alloc_id_o = alloc_ptr_r;

  // head waits for its own reply, later replies stay parked
  assign deq_v_o    = done_r[deq_ptr_r];
  assign deq_type_o = type_mem[deq_ptr_r];
  assign deq_addr_o = addr_mem[deq_ptr_r];
  assign deq_tag_o  = tag_mem[deq_ptr_r];
  assign deq_data_o = data_mem[deq_ptr_r];

endmodule

//--- bridge/dram_hash.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module dram_hash
  (
    input  noc_pkg::dram_eva_u      eva_i,
    input  logic [`POD_X_W-1:0]     pod_x_i,
    input  logic [`POD_Y_W-1:0]     pod_y_i,
    output logic [`NOC_X_W-1:0]     x_o,
    output logic [`NOC_Y_W-1:0]     y_o,
    output logic [`NOC_ADDR_W-1:0]  epa_o
  );

  import noc_pkg::*;

  localparam int x_w   = `NOC_X_W;
  localparam int y_w   = `NOC_Y_W;
  localparam int epa_w = `NOC_ADDR_W;

  logic [x_w-1:0] x_base;
  logic [y_w-1:0] y_base;
  logic [y_w-1:0] y_row;

  // pod origin in tile coordinates
  // each pod spans the tile rows plus a cache row above and below
  assign x_base = x_w'(pod_x_i) * x_w'(`TILES_X);
  assign y_base = y_w'(pod_y_i) * y_w'(`TILES_Y + 2);

  // top bank bit selects the south cache row
  assign y_row = eva_i.hash.bank[eva_bank_w-1] ? y_w'(`TILES_Y + 1) : '0;

  // low bank bits pick the column inside the pod
  assign x_o = x_base + x_w'(eva_i.hash.bank[eva_x_sub_w-1:0]);
  assign y_o = y_base + y_row;

  // word address inside the bank, block tag above the word index
  assign epa_o = epa_w'({eva_i.hash.tag, eva_i.hash.word});

endmodule

//--- src/bridge_cfg.sv
`timescale 1ns/1ps
`include "bridge_settings.svh"

module bridge_cfg
  (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 cfg_we_i,
    input  logic [1:0]           cfg_addr_i,
    input  logic [`DATA_W-1:0]   cfg_data_i,
    output logic [`PADDR_W-2:0]  cfg_offset_o,
    output logic [`POD_X_W-1:0]  cfg_pod_x_o,
    output logic [`POD_Y_W-1:0]  cfg_pod_y_o,
    output logic [`NOC_X_W-1:0]  cfg_src_x_o,
    output logic [`NOC_Y_W-1:0]  cfg_src_y_o
  );

  logic [`PADDR_W-2:0]          offset_r;
  logic [`POD_X_W+`POD_Y_W-1:0] pod_r;
  logic [`NOC_X_W+`NOC_Y_W-1:0] src_r;

  // software write port, address 3 is unused
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      offset_r <= '0;
      pod_r    <= '0;
      src_r    <= '0;
    end
    else if (cfg_we_i)
    begin
      case (cfg_addr_i)
        2'd0: offset_r <= cfg_data_i[`PADDR_W-2:0];
        2'd1: pod_r    <= cfg_data_i[`POD_X_W+`POD_Y_W-1:0];
        2'd2: src_r    <= cfg_data_i[`NOC_X_W+`NOC_Y_W-1:0];
        default: ;
      endcase
    end
  end

  assign cfg_offset_o = offset_r;

  // y sits in the low bits, x above it
  assign cfg_pod_y_o = pod_r[`POD_Y_W-1:0];
  assign cfg_pod_x_o = pod_r[`POD_Y_W+:`POD_X_W];
  assign cfg_src_y_o = src_r[`NOC_Y_W-1:0];
  assign cfg_src_x_o = src_r[`NOC_Y_W+:`NOC_X_W];

endmodule

//--- common/noc_pkg.sv
`include "bridge_settings.svh"

package noc_pkg;

  // remote opcodes issued toward the dram caches
  typedef enum logic [1:0] {
    e_remote_load = 2'b00,
    e_remote_sw   = 2'b01
  } noc_op_e;

  // --------------------
  // dram address layout
  localparam int eva_x_sub_w = $clog2(`TILES_X);
  localparam int eva_bank_w  = eva_x_sub_w + 1;
  localparam int eva_word_w  = $clog2(`BLOCK_WORDS);
  localparam int eva_byte_w  = 2;
  localparam int eva_tag_w   = `PADDR_W - 1 - eva_bank_w - eva_word_w - eva_byte_w;

  // flag plus linear address, as seen after the offset is added
  typedef struct packed {
    logic                dram;
    logic [`PADDR_W-2:0] addr;
  } dram_eva_offset_s;

  // same word split into the fields the hash works on
  typedef struct packed {
    logic                  dram;
    logic [eva_tag_w-1:0]  tag;
    logic [eva_bank_w-1:0] bank;
    logic [eva_word_w-1:0] word;
    logic [eva_byte_w-1:0] byte_off;
  } dram_eva_hash_s;

  typedef union packed {
    dram_eva_offset_s offset;
    dram_eva_hash_s   hash;
  } dram_eva_u;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

  // message kinds on the forward and reverse channels
  // only single-word transfers are carried
  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_msg_e;

endpackage

//--- common/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// processor side
`define PADDR_W 32
`define TAG_W 4

// network words and coordinates
`define DATA_W 32
`define NOC_ADDR_W 28
`define NOC_X_W 7
`define NOC_Y_W 7
`define REG_ID_W 5

// pod geometry
`define POD_X_W 3
`define POD_Y_W 3
`define TILES_X 4
`define TILES_Y 8
`define BLOCK_WORDS 8

// --------------------
// buffering and flow control
`define OUTSTANDING 8
`define NOC_CREDITS 4
`define NOC_FIFO_ELS 2

`endif
